// File: src/axi_pkg.sv
package axi_pkg;

  localparam int AXI_ID_W   = 4;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;

  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  typedef logic [7:0]            axi_len_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  // Bytes per beat as log2
  function automatic logic [2:0] axi_size_of(input int data_w);
    case (data_w)
      16:      return 3'b001;
      32:      return 3'b010;
      64:      return 3'b011;
      128:     return 3'b100;
      256:     return 3'b101;
      512:     return 3'b110;
      1024:    return 3'b111;
      default: return 3'b000;
    endcase
  endfunction

  typedef struct packed {
    logic       valid;
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;

  typedef struct packed {
    logic      valid;
    axi_id_t   id;
    axi_data_t data;
    logic      last;
  } axi_r_t;

endpackage

// File: src/read_port_pkg.sv
package read_port_pkg;

  typedef logic [11:0] byte_len_t;

  // Client request, start is a one-cycle pulse
  typedef struct packed {
    logic        start;
    logic [31:0] addr;
    byte_len_t   len;
  } read_req_t;

  localparam int MAX_BURST_BEATS = 16;
  localparam int BOUNDARY_BYTES  = 4096;

  typedef enum logic [1:0] {
    IDLE,
    ADDR_SETUP,
    ADDR,
    DATA
  } port_state_e;

endpackage

// File: src/transfer_controller.sv
`timescale 1ns/1ps

module transfer_controller (
  input  logic                     clk,
  input  logic                     rst,
  input  axi_pkg::axi_addr_t       address,
  input  read_port_pkg::byte_len_t length,
  input  logic                     transfer_start,
  input  logic                     burst_start,
  output axi_pkg::axi_addr_t       axaddr,
  output axi_pkg::axi_len_t        axlen,
  output logic                     last_transfer
);
  import axi_pkg::*;
  import read_port_pkg::*;

  localparam int BND_W = $clog2(BOUNDARY_BYTES);

  axi_addr_t cur_addr;
  byte_len_t remaining;   // Beats not yet requested
  byte_len_t total_words;
  byte_len_t bound_beats;
  byte_len_t burst_beats;
  logic      last_q;

  assign total_words = byte_len_t'((13'(length) + 13'd3) >> 2);

  // Beats left before the next 4 KB line
  assign bound_beats = byte_len_t'((BOUNDARY_BYTES - int'(cur_addr[BND_W-1:0])) / 4);

  always_comb begin
    burst_beats = remaining;
    if (burst_beats > byte_len_t'(MAX_BURST_BEATS)) begin
      burst_beats = byte_len_t'(MAX_BURST_BEATS);
    end
    if (burst_beats > bound_beats) begin
      burst_beats = bound_beats;
    end
  end

  assign axaddr        = cur_addr;
  assign axlen         = axi_len_t'(burst_beats - 1'b1);
  assign last_transfer = last_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cur_addr  <= '0;
      remaining <= '0;
      last_q    <= 1'b0;
    end else if (transfer_start) begin
      cur_addr  <= {address[AXI_ADDR_W-1:2], 2'b00};
      // One extra beat when the start is not word aligned
      remaining <= total_words + byte_len_t'(address[1:0] != 2'b00);
      last_q    <= 1'b0;
    end else if (burst_start) begin
      cur_addr  <= cur_addr + (axi_addr_t'(burst_beats) << 2);
      remaining <= remaining - burst_beats;
      last_q    <= (remaining == burst_beats); // Burst in flight is the final one
    end
  end

endmodule

// File: src/burst_align.sv
`timescale 1ns/1ps

module burst_align (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [1:0]               offset,
  input  logic                     start,
  input  axi_pkg::axi_data_t       beat,
  input  logic                     beat_valid,
  input  read_port_pkg::byte_len_t word_count,
  output axi_pkg::axi_data_t       word,
  output logic                     word_valid,
  output logic                     word_last,
  output logic                     empty
);
  import axi_pkg::*;
  import read_port_pkg::*;

  logic [1:0] off_q;
  byte_len_t  total;
  byte_len_t  count;    // Words emitted so far
  logic       active;
  logic       primed;   // Hold register carries a beat
  axi_data_t  hold;

  assign word_valid = active && beat_valid && (off_q == 2'd0 || primed);
  assign word_last  = word_valid && (count == total - 1'b1);
  assign empty      = !active;

  // Upper bytes of the held beat, lower bytes of the new one
  always_comb begin
    case (off_q)
      2'd1:    word = {beat[7:0], hold[31:8]};
      2'd2:    word = {beat[15:0], hold[31:16]};
      2'd3:    word = {beat[23:0], hold[31:24]};
      default: word = beat;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      off_q  <= 2'd0;
      total  <= '0;
      count  <= '0;
      active <= 1'b0;
      primed <= 1'b0;
    end else if (start) begin
      off_q  <= offset;
      total  <= word_count;
      count  <= '0;
      active <= 1'b1;
      primed <= 1'b0;
    end else if (active && beat_valid) begin
      primed <= 1'b1;
      if (word_valid) begin
        count <= count + 1'b1;
      end
      if (word_last) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid) begin
      hold <= beat;
    end
  end

endmodule

// File: src/simple_axi_read.sv
`timescale 1ns/1ps

module simple_axi_read #(
  parameter int PORT_ID = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  read_port_pkg::read_req_t req,
  input  logic                     ar_ready,
  input  axi_pkg::axi_r_t          r,
  output logic                     busy,
  output axi_pkg::axi_data_t       word,
  output logic                     word_valid,
  output logic                     word_last,
  output axi_pkg::axi_ar_t         ar,
  output logic                     r_ready
);
  import axi_pkg::*;
  import read_port_pkg::*;

  port_state_e state;
  logic        ar_valid;
  axi_len_t    len_q;
  axi_addr_t   axaddr;
  axi_len_t    axlen;
  byte_len_t   word_count;
  logic        transfer_start;
  logic        burst_start;
  logic        last_transfer;
  logic        beat_ok;
  logic        align_empty;

  assign busy           = (state != IDLE) || !align_empty;
  assign transfer_start = req.start && !busy;
  assign burst_start    = (state == ADDR) && ar_ready;
  assign r_ready        = (state == DATA);
  assign beat_ok        = r.valid && r_ready && (r.id == axi_id_t'(PORT_ID));
  assign word_count     = byte_len_t'((13'(req.len) + 13'd3) >> 2);

  assign ar = '{
    valid: ar_valid,
    id:    axi_id_t'(PORT_ID),
    addr:  axaddr,
    len:   len_q,
    size:  axi_size_of(AXI_DATA_W),
    burst: AXI_BURST_INCR
  };

  transfer_controller i_ctrl (
    .clk           (clk),
    .rst           (rst),
    .address       (req.addr),
    .length        (req.len),
    .transfer_start(transfer_start),
    .burst_start   (burst_start),
    .axaddr        (axaddr),
    .axlen         (axlen),
    .last_transfer (last_transfer)
  );

  burst_align i_align (
    .clk       (clk),
    .rst       (rst),
    .offset    (req.addr[1:0]),
    .start     (transfer_start),
    .beat      (r.data),
    .beat_valid(beat_ok),
    .word_count(word_count),
    .word      (word),
    .word_valid(word_valid),
    .word_last (word_last),
    .empty     (align_empty)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= IDLE;
      ar_valid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (transfer_start) state <= ADDR_SETUP;
        end
        ADDR_SETUP: begin
          ar_valid <= 1'b1;
          state    <= ADDR;
        end
        ADDR: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= DATA;
          end
        end
        DATA: begin
          if (beat_ok && r.last) begin
            state <= last_transfer ? IDLE : ADDR_SETUP;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Length frozen for the whole address phase
  always_ff @(posedge clk) begin
    if (state == ADDR_SETUP) len_q <= axlen;
  end

endmodule

// File: src/axi_read_arbiter.sv
`timescale 1ns/1ps

module axi_read_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  axi_pkg::axi_ar_t ar0,
  input  axi_pkg::axi_ar_t ar1,
  input  logic             r0_ready,
  input  logic             r1_ready,
  input  logic             m_ar_ready,
  input  axi_pkg::axi_r_t  m_r,
  output logic             ar0_ready,
  output logic             ar1_ready,
  output axi_pkg::axi_r_t  r0,
  output axi_pkg::axi_r_t  r1,
  output axi_pkg::axi_ar_t m_ar,
  output logic             m_r_ready
);
  localparam int NUM_PORTS = 2;
  localparam int SEL_W     = $clog2(NUM_PORTS);

  logic [NUM_PORTS-1:0] pending;
  logic [SEL_W-1:0]     prio;      // Port with first claim
  logic [SEL_W-1:0]     grant_c;
  logic [SEL_W-1:0]     grant_q;
  logic [SEL_W-1:0]     sel;
  logic                 locked;
  logic                 burst_done;

  assign pending = {ar1.valid, ar0.valid};

  always_comb begin
    grant_c = prio;
    if (!pending[prio]) grant_c = ~prio;
  end

  assign sel        = locked ? grant_q : grant_c;
  assign m_ar       = sel[0] ? ar1 : ar0;
  assign ar0_ready  = m_ar_ready && !sel[0];
  assign ar1_ready  = m_ar_ready && sel[0];
  assign m_r_ready  = locked && (grant_q[0] ? r1_ready : r0_ready);
  assign burst_done = locked && m_r.valid && m_r_ready && m_r.last;

  // R beats go only to the port holding the lock
  always_comb begin
    r0       = m_r;
    r1       = m_r;
    r0.valid = m_r.valid && locked && !grant_q[0];
    r1.valid = m_r.valid && locked && grant_q[0];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      locked  <= 1'b0;
      grant_q <= '0;
      prio    <= '0;
    end else if (!locked) begin
      if (|pending) begin
        locked  <= 1'b1;
        grant_q <= grant_c;
        prio    <= ~grant_c;
      end
    end else if (burst_done) begin
      locked <= 1'b0;
    end
  end

endmodule

// File: src/dual_read_top.sv
`timescale 1ns/1ps

module dual_read_top (
  input  logic                     clk,
  input  logic                     rst,
  input  read_port_pkg::read_req_t req0,
  input  read_port_pkg::read_req_t req1,
  input  logic                     ar_ready,
  input  axi_pkg::axi_r_t          r,
  output logic                     busy0,
  output logic                     busy1,
  output axi_pkg::axi_data_t       word0,
  output axi_pkg::axi_data_t       word1,
  output logic                     word_valid0,
  output logic                     word_valid1,
  output logic                     word_last0,
  output logic                     word_last1,
  output axi_pkg::axi_ar_t         ar,
  output logic                     r_ready
);
  import axi_pkg::*;

  axi_ar_t ar0;
  axi_ar_t ar1;
  axi_r_t  r0;
  axi_r_t  r1;
  logic    ar0_ready;
  logic    ar1_ready;
  logic    r0_ready;
  logic    r1_ready;

  simple_axi_read #(.PORT_ID(0)) i_port0 (
    .clk       (clk),
    .rst       (rst),
    .req       (req0),
    .ar_ready  (ar0_ready),
    .r         (r0),
    .busy      (busy0),
    .word      (word0),
    .word_valid(word_valid0),
    .word_last (word_last0),
    .ar        (ar0),
    .r_ready   (r0_ready)
  );

  simple_axi_read #(.PORT_ID(1)) i_port1 (
    .clk       (clk),
    .rst       (rst),
    .req       (req1),
    .ar_ready  (ar1_ready),
    .r         (r1),
    .busy      (busy1),
    .word      (word1),
    .word_valid(word_valid1),
    .word_last (word_last1),
    .ar        (ar1),
    .r_ready   (r1_ready)
  );

  axi_read_arbiter i_arb (
    .clk       (clk),
    .rst       (rst),
    .ar0       (ar0),
    .ar1       (ar1),
    .r0_ready  (r0_ready),
    .r1_ready  (r1_ready),
    .m_ar_ready(ar_ready),
    .m_r       (r),
    .ar0_ready (ar0_ready),
    .ar1_ready (ar1_ready),
    .r0        (r0),
    .r1        (r1),
    .m_ar      (ar),
    .m_r_ready (r_ready)
  );

endmodule

// File: tests/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall_en,
  input  logic             alt_check,
  input  axi_pkg::axi_ar_t ar,
  input  logic             r_ready,
  output logic             ar_ready,
  output axi_pkg::axi_r_t  r,
  output int               proto_errors
);
  import axi_pkg::*;

  logic [31:0] rng;
  logic        in_burst;
  logic        ar_hs;
  logic        r_hs;
  logic        prev_seen;   // Last accepted ID counts for alternation
  axi_id_t     prev_id;
  axi_ar_t     ar_q;        // AR fields at acceptance
  axi_addr_t   beat_addr;
  axi_len_t    beat_idx;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Pattern byte depends on the whole address
  function automatic logic [7:0] byte_at(input axi_addr_t a);
    axi_addr_t v;
    v = a * 32'd7 + 32'd3 + (a >> 8);
    return v[7:0];
  endfunction

  task automatic check_ar(input axi_ar_t a);
    int span;
    span = int'(a.addr[11:0]) + (int'(a.len) + 1) * 4;
    // 4-byte beats, INCR bursts
    if (a.size != 3'b010) begin
      $display("FAIL %0d ns: ar.size = %0d, expected %0d", $time, a.size, 2);
      proto_errors++;
    end
    if (a.burst != 2'b01) begin
      $display("FAIL %0d ns: ar.burst = %0d, expected %0d", $time, a.burst, 1);
      proto_errors++;
    end
    if (a.len > 8'd15) begin
      $display("Burst at %h asks for %0d beats, more than 16", a.addr, int'(a.len) + 1);
      proto_errors++;
    end
    if (span > 4096) begin
      $display("Burst at %h of %0d beats crosses a 4 KB boundary", a.addr, int'(a.len) + 1);
      proto_errors++;
    end
    if (alt_check && prev_seen && a.id == prev_id) begin
      $display("Port %0d won the read channel twice in a row while the other waited", a.id);
      proto_errors++;
    end
    prev_seen = alt_check;
    prev_id   = a.id;
  endtask

  initial begin
    rng          = SEED;
    in_burst     = 1'b0;
    prev_seen    = 1'b0;
    prev_id      = '0;
    ar_q         = '0;
    beat_addr    = '0;
    beat_idx     = '0;
    ar_ready     = 1'b0;
    r            = '0;
    proto_errors = 0;
    forever begin
      @(negedge clk);
      ar_hs = ar.valid && ar_ready;
      r_hs  = r.valid && r_ready;
      if (in_burst && ar.valid) begin
        $display("Address request at %0d ns while a burst was still returning", $time);
        proto_errors++;
      end
      if (ar_hs) begin
        ar_q = ar;
        check_ar(ar);
      end
      @(posedge clk);
      #1;
      rng = lcg_next(rng);
      if (rst) begin
        in_burst = 1'b0;
      end else if (ar_hs) begin
        in_burst  = 1'b1;
        beat_addr = {ar_q.addr[31:2], 2'b00};
        beat_idx  = '0;
      end else if (r_hs) begin
        in_burst  = (beat_idx != ar_q.len);
        beat_addr = beat_addr + 32'd4;
        beat_idx  = beat_idx + 8'd1;
      end
      ar_ready = !rst && !in_burst && !(stall_en && rng[31:30] == 2'b00);
      r.valid  = in_burst && !(stall_en && rng[29:28] == 2'b00);
      r.id     = ar_q.id;
      r.data   = {byte_at(beat_addr + 32'd3), byte_at(beat_addr + 32'd2),
                  byte_at(beat_addr + 32'd1), byte_at(beat_addr)};
      r.last   = (beat_idx == ar_q.len);
    end
  end

endmodule

// File: tests/tb_dual_read.sv
`timescale 1ns/1ps

module tb_dual_read;
  import axi_pkg::*;
  import read_port_pkg::*;

  localparam logic [31:0] SEED = 32'h5f9619c6;
  // Aligned, unaligned, split, shared, busy, then stress at 65 beats worst case
  localparam int TOTAL_BEATS    = 8 + 30 + 50 + 64 + 16 + 30 * 65;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS + 2000;

  logic        clk;
  logic        rst;
  read_req_t   req0;
  read_req_t   req1;
  logic        ar_ready;
  axi_r_t      r;
  logic        busy0;
  logic        busy1;
  axi_data_t   word0;
  axi_data_t   word1;
  logic        word_valid0;
  logic        word_valid1;
  logic        word_last0;
  logic        word_last1;
  axi_ar_t     ar;
  logic        r_ready;
  logic        stall_en;
  logic        alt_check;
  int          proto_errors;

  axi_data_t   word_p [2];
  logic [1:0]  valid_p;
  logic [1:0]  last_p;
  logic [1:0]  busy_p;
  logic [1:0]  last_seen;      // word_last in the previous cycle

  logic [31:0] exp_addr [2];   // Request under check, per port
  byte_len_t   exp_len [2];
  int          word_idx [2];
  logic [1:0]  exp_active;

  logic [31:0] rng_state;
  int          err_count;
  int          errs_before;
  int          tests_passed;
  int          tests_failed;
  int          cycles;

  assign word_p[0] = word0;
  assign word_p[1] = word1;
  assign valid_p   = {word_valid1, word_valid0};
  assign last_p    = {word_last1, word_last0};
  assign busy_p    = {busy1, busy0};

  dual_read_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .req0       (req0),
    .req1       (req1),
    .ar_ready   (ar_ready),
    .r          (r),
    .busy0      (busy0),
    .busy1      (busy1),
    .word0      (word0),
    .word1      (word1),
    .word_valid0(word_valid0),
    .word_valid1(word_valid1),
    .word_last0 (word_last0),
    .word_last1 (word_last1),
    .ar         (ar),
    .r_ready    (r_ready)
  );

  axi_mem_model #(.SEED(SEED)) i_mem (
    .clk         (clk),
    .rst         (rst),
    .stall_en    (stall_en),
    .alt_check   (alt_check),
    .ar          (ar),
    .r_ready     (r_ready),
    .ar_ready    (ar_ready),
    .r           (r),
    .proto_errors(proto_errors)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    logic [31:0] v;
    v = a * 32'd7 + 32'd3 + (a >> 8);
    return v[7:0];
  endfunction

  // Word k holds the bytes from addr + 4k upward, lowest byte first
  function automatic logic [31:0] expected_word(input logic [31:0] addr, input int k);
    logic [31:0] w;
    logic [31:0] base;
    base = addr + 32'(4 * k);
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = mem_byte(base + 32'(i));
    end
    return w;
  endfunction

  function automatic int words_for(input byte_len_t len);
    return (int'(len) + 3) / 4;
  endfunction

  task automatic drive_req(input int p, input logic [31:0] addr, input byte_len_t len);
    if (p == 0) req0 = '{start: 1'b1, addr: addr, len: len};
    else req1 = '{start: 1'b1, addr: addr, len: len};
    exp_addr[p]   = addr;
    exp_len[p]    = len;
    word_idx[p]   = 0;
    exp_active[p] = 1'b1;
  endtask

  task automatic end_pulse();
    @(posedge clk);
    #1;
    req0.start = 1'b0;
    req1.start = 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk);
      #1;
    end while (busy0 || busy1);
    for (int p = 0; p < 2; p++) begin
      if (exp_active[p]) begin
        $display("Port %0d went idle at %0d ns before its last word", p, $time);
        err_count++;
        exp_active[p] = 1'b0;
      end
    end
  endtask

  task automatic draw_request(output logic [31:0] addr, output byte_len_t len);
    rng_state = lcg_next(rng_state);
    addr      = {16'h0000, rng_state[31:16]};
    rng_state = lcg_next(rng_state);
    len       = byte_len_t'(rng_state[31:16] % 16'd255) + 12'd1;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_count + proto_errors;
    if (errs == errs_before) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errs - errs_before);
    end
    errs_before = errs;
  endtask

  always @(negedge clk) begin
    logic [31:0] want;
    logic        last_want;
    for (int p = 0; p < 2; p++) begin
      if (last_seen[p] && busy_p[p]) begin
        $display("Port %0d still busy at %0d ns, one cycle after its last word", p, $time);
        err_count++;
      end
      last_seen[p] = last_p[p];
      if (last_p[p] && !valid_p[p]) begin
        $display("Port %0d raised word_last without a word at %0d ns", p, $time);
        err_count++;
      end
      if (valid_p[p] && !exp_active[p]) begin
        $display("Port %0d delivered a word at %0d ns with no read outstanding", p, $time);
        err_count++;
      end else if (valid_p[p]) begin
        want      = expected_word(exp_addr[p], word_idx[p]);
        last_want = (word_idx[p] == words_for(exp_len[p]) - 1);
        if (word_p[p] !== want) begin
          $display("FAIL %0d ns: word%0d = %h, expected %h", $time, p, word_p[p], want);
          err_count++;
        end
        if (last_p[p] !== last_want) begin
          $display("FAIL %0d ns: word_last%0d = %b, expected %b", $time, p, last_p[p],
                   last_want);
          err_count++;
        end
        word_idx[p]++;
        if (last_want) exp_active[p] = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    logic [31:0] a0;
    logic [31:0] a1;
    byte_len_t   l0;
    byte_len_t   l1;
    rst        = 1'b1;
    req0       = '0;
    req1       = '0;
    stall_en   = 1'b0;
    alt_check  = 1'b0;
    exp_active = '0;
    last_seen  = '0;
    rng_state  = SEED;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    @(posedge clk);
    #1;
    if (busy0 || busy1 || word_valid0 || word_valid1 || ar.valid || r_ready) begin
      $display("Port outputs were not idle after reset");
      err_count++;
    end
    drive_req(0, 32'h0000_0100, 12'd32);
    end_pulse();
    wait_idle();
    finish_test("1 reset and aligned read");

    for (int o = 1; o < 4; o++) begin
      for (int i = 0; i < 3; i++) begin
        l1 = (i == 0) ? 12'd1 : (i == 1) ? 12'd5 : 12'd13;
        drive_req(1, 32'h0000_0400 + 32'(64 * (3 * o + i) + o), l1);
        end_pulse();
        wait_idle();
      end
    end
    finish_test("2 unaligned reads");

    stall_en = 1'b1;
    drive_req(0, 32'h0000_1FEC, 12'd200);  // 20 bytes below a 4 KB line
    end_pulse();
    wait_idle();
    finish_test("3 burst splitting");

    alt_check = 1'b1;
    drive_req(0, 32'h0000_3000, 12'd128);
    drive_req(1, 32'h0000_5000, 12'd128);
    end_pulse();
    wait_idle();
    alt_check = 1'b0;
    finish_test("4 shared channel");

    drive_req(0, 32'h0000_6000, 12'd64);
    end_pulse();
    @(posedge clk);
    #1;
    if (!busy0) begin
      $display("Port 0 was not busy when the second start pulse went out");
      err_count++;
    end
    req0 = '{start: 1'b1, addr: 32'h0000_7000, len: 12'd40};
    end_pulse();
    wait_idle();
    repeat (30) @(posedge clk);
    #1;
    if (busy0) begin
      $display("Port 0 took up a start pulse that came while it was busy");
      err_count++;
    end
    finish_test("5 busy rule");

    for (int n = 0; n < 15; n++) begin
      draw_request(a0, l0);
      draw_request(a1, l1);
      drive_req(0, a0, l0);
      drive_req(1, a1, l1);
      end_pulse();
      wait_idle();
    end
    finish_test("6 random stress");

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count + proto_errors == errs_before) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb.f
src/axi_pkg.sv
src/read_port_pkg.sv
src/transfer_controller.sv
src/burst_align.sv
src/simple_axi_read.sv
src/axi_read_arbiter.sv
src/dual_read_top.sv
tests/axi_mem_model.sv
tests/tb_dual_read.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dual_read -f tb.f -o sim_dual_read
./obj_dir/sim_dual_read | tee sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0
